/* soc_pkg.sv */
package soc_pkg;

    // Data path widths
    localparam int REG_WIDTH  = 64;
    localparam int ADDR_WIDTH = 64;
    localparam int KB_WIDTH   = 8;   // One PS/2 scan code
    localparam int SWT_WIDTH  = 8;
    localparam int LED_WIDTH  = 16;
    localparam int SEG_WIDTH  = 32;  // Eight hex digits

    // Address map of the I/O block
    localparam logic [ADDR_WIDTH-1:0] ADDR_RAM = 64'h0000_0000_8000_0000;
    localparam int                    RAM_LEN  = 4096;  // Bytes
    localparam logic [ADDR_WIDTH-1:0] KBD_ADDR = 64'h0000_0000_A000_0060;
    localparam logic [ADDR_WIDTH-1:0] SWT_ADDR = 64'h0000_0000_A000_0070;
    localparam logic [ADDR_WIDTH-1:0] SEG_ADDR = 64'h0000_0000_A000_0080;
    localparam logic [ADDR_WIDTH-1:0] LED_ADDR = 64'h0000_0000_A000_0090;
    localparam int                    PERI_LEN = 8;     // Each peripheral owns one doubleword

    // Access width of a load or store where the U forms zero-extend on read
    typedef enum logic [2:0] {
        WDT_B,
        WDT_H,
        WDT_W,
        WDT_D,
        WDT_BU,
        WDT_HU,
        WDT_WU
    } wdt_e;

    // True when addr lies in [base, base + len)
    function automatic logic in_window(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [ADDR_WIDTH-1:0] base,
        input int unsigned           len
    );
        logic [ADDR_WIDTH-1:0] offset;
        offset = addr - base;
        // The first term guards against wrap below the base
        return (addr >= base) && (offset < ADDR_WIDTH'(len));
    endfunction

endpackage

/* mem_if.sv */
`timescale 1ns/1ps

interface mem_if;
    import soc_pkg::*;

    logic [ADDR_WIDTH-1:0] raddr;   // Byte offset into the RAM
    logic [ADDR_WIDTH-1:0] waddr;
    logic [REG_WIDTH-1:0]  wdata;
    logic                  wen;
    logic                  ren;
    wdt_e                  wdt_op;
    logic [REG_WIDTH-1:0]  rdata;   // Already extended to the full width

    // Decoder side
    modport ctrl (output raddr, waddr, wdata, wen, ren, wdt_op, input rdata);

    // Memory side
    modport mem (input raddr, waddr, wdata, wen, ren, wdt_op, output rdata);

endinterface

/* ps2_kbd_rx.sv */
`timescale 1ns/1ps

module ps2_kbd_rx (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ps2_clk,
    input  logic                         ps2_data,
    output logic [soc_pkg::KB_WIDTH-1:0] code,
    output logic                         code_valid
);
    import soc_pkg::*;

    // Start bit, data bits, odd parity, stop bit
    localparam int FRAME_BITS = KB_WIDTH + 3;

    logic [2:0]            clk_sync;    // Two synchronizer stages plus the previous level
    logic [1:0]            data_sync;
    logic                  clk_fall;
    logic [3:0]            bit_cnt;
    logic [FRAME_BITS-1:0] frame_q;
    logic [FRAME_BITS-1:0] frame_next;
    logic                  frame_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 3'b111;        // Idle lines are high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // Bits arrive LSB first, so the frame shifts in from the top
    assign frame_next = {data_sync[1], frame_q[FRAME_BITS-1:1]};

    // Start low, stop high, and an odd number of ones over data and parity
    assign frame_ok = ~frame_next[0] & frame_next[FRAME_BITS-1]
                    & (^frame_next[KB_WIDTH+1:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    bit_cnt    <= '0;
                    code_valid <= frame_ok;   // A bad frame is simply dropped
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            frame_q <= frame_next;
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                code <= frame_next[KB_WIDTH:1];
            end
        end
    end

endmodule

/* kb_fifo.sv */
`timescale 1ns/1ps

module kb_fifo #(
    parameter int KB_FIFO_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  logic [soc_pkg::KB_WIDTH-1:0] push_data,
    input  logic                         pop,
    output logic [soc_pkg::KB_WIDTH-1:0] head,
    output logic                         not_empty
);
    import soc_pkg::*;

    localparam int PTR_W = (KB_FIFO_DEPTH > 1) ? $clog2(KB_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(KB_FIFO_DEPTH + 1);

    logic [KB_WIDTH-1:0] buf_q [KB_FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    assign full      = (count == CNT_W'(KB_FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push & ~full;        // Codes arriving while full are lost
    assign do_pop    = pop & not_empty;
    assign head      = buf_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(KB_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(KB_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count as it is
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_q[wr_ptr] <= push_data;
        end
    end

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_BYTES = soc_pkg::RAM_LEN
) (
    input logic clk,
    mem_if.mem  bus
);
    import soc_pkg::*;

    localparam int WORDS = RAM_BYTES / 8;
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [REG_WIDTH-1:0] ram_q [WORDS];
    logic [IDX_W-1:0]     widx;
    logic [IDX_W-1:0]     ridx;
    logic [2:0]           woff;
    logic [2:0]           roff;
    logic [7:0]           wmask;
    logic [REG_WIDTH-1:0] wshift;
    logic [REG_WIDTH-1:0] rshift;
    logic [REG_WIDTH-1:0] rfield;

    // Byte lanes touched by an access of the given size at offset zero
    function automatic logic [7:0] size_mask(input wdt_e op);
        case (op)
            WDT_B, WDT_BU: return 8'h01;
            WDT_H, WDT_HU: return 8'h03;
            WDT_W, WDT_WU: return 8'h0f;
            default:       return 8'hff;
        endcase
    endfunction

    assign widx = bus.waddr[3 +: IDX_W];
    assign ridx = bus.raddr[3 +: IDX_W];
    assign woff = bus.waddr[2:0];
    assign roff = bus.raddr[2:0];

    // Move the low bytes of the store data up to their lanes
    assign wmask  = size_mask(bus.wdt_op) << woff;
    assign wshift = bus.wdata << {woff, 3'b000};

    always_ff @(posedge clk) begin
        if (bus.wen) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask[i]) begin
                    ram_q[widx][8*i +: 8] <= wshift[8*i +: 8];
                end
            end
        end
    end

    assign rshift = ram_q[ridx] >> {roff, 3'b000};   // Field now sits at bit 0

    always_comb begin
        case (bus.wdt_op)
            WDT_B:   rfield = {{(REG_WIDTH-8){rshift[7]}}, rshift[7:0]};
            WDT_H:   rfield = {{(REG_WIDTH-16){rshift[15]}}, rshift[15:0]};
            WDT_W:   rfield = {{(REG_WIDTH-32){rshift[31]}}, rshift[31:0]};
            WDT_BU:  rfield = {{(REG_WIDTH-8){1'b0}}, rshift[7:0]};
            WDT_HU:  rfield = {{(REG_WIDTH-16){1'b0}}, rshift[15:0]};
            WDT_WU:  rfield = {{(REG_WIDTH-32){1'b0}}, rshift[31:0]};
            default: rfield = rshift;
        endcase
    end

    assign bus.rdata = bus.ren ? rfield : '0;

endmodule

/* mmio.sv */
`timescale 1ns/1ps

module mmio (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] mem_raddr,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] mem_waddr,
    input  logic [soc_pkg::REG_WIDTH-1:0]  mem_wdata,
    input  logic                           mem_wen,
    input  logic                           mem_ren,
    input  soc_pkg::wdt_e                  mem_wdt_op,
    input  logic [soc_pkg::KB_WIDTH-1:0]   kb_rdata,    // Head of the scan-code FIFO
    input  logic                           kb_ready,
    input  logic [soc_pkg::SWT_WIDTH-1:0]  swt_rdata,
    output logic [soc_pkg::REG_WIDTH-1:0]  mem_rdata,
    output logic                           sig_rd_kb,
    output logic [soc_pkg::SEG_WIDTH-1:0]  seg_wdata,
    output logic [soc_pkg::LED_WIDTH-1:0]  led_wdata,
    mem_if.ctrl                            ram
);
    import soc_pkg::*;

    logic rd_ram;
    logic rd_kbd;
    logic rd_swt;
    logic wr_ram;
    logic wr_seg;
    logic wr_led;

    assign rd_ram = in_window(mem_raddr, ADDR_RAM, RAM_LEN);
    assign rd_kbd = in_window(mem_raddr, KBD_ADDR, PERI_LEN);
    assign rd_swt = in_window(mem_raddr, SWT_ADDR, PERI_LEN);
    assign wr_ram = in_window(mem_waddr, ADDR_RAM, RAM_LEN);
    assign wr_seg = in_window(mem_waddr, SEG_ADDR, PERI_LEN);
    assign wr_led = in_window(mem_waddr, LED_ADDR, PERI_LEN);

    // The RAM sees offsets from its base
    assign ram.raddr  = mem_raddr - ADDR_RAM;
    assign ram.waddr  = mem_waddr - ADDR_RAM;
    assign ram.wdata  = mem_wdata;
    assign ram.wdt_op = mem_wdt_op;
    assign ram.ren    = mem_ren & rd_ram;
    assign ram.wen    = mem_wen & wr_ram;    // Stores elsewhere never reach the array

    always_comb begin
        mem_rdata = '0;                      // Unmapped or empty keyboard reads give zero
        sig_rd_kb = 1'b0;
        if (mem_ren) begin
            if (rd_ram) begin
                mem_rdata = ram.rdata;
            end else if (rd_kbd) begin
                if (kb_ready) begin
                    sig_rd_kb = 1'b1;        // FIFO pops on this clock edge
                    mem_rdata = REG_WIDTH'(kb_rdata);
                end
            end else if (rd_swt) begin
                mem_rdata = REG_WIDTH'(swt_rdata);
            end
        end
    end

    // Peripheral registers take the low part of the store data
    always_ff @(posedge clk) begin
        if (rst) begin
            seg_wdata <= '0;
            led_wdata <= '0;
        end else if (mem_wen) begin
            if (wr_seg) begin
                seg_wdata <= mem_wdata[SEG_WIDTH-1:0];
            end
            if (wr_led) begin
                led_wdata <= mem_wdata[LED_WIDTH-1:0];
            end
        end
    end

endmodule

/* seg_scan.sv */
`timescale 1ns/1ps

module seg_scan #(
    parameter int SCAN_CYCLES = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [soc_pkg::SEG_WIDTH-1:0] value,
    output logic [7:0]                    seg_an,
    output logic [6:0]                    seg_cathode
);
    import soc_pkg::*;

    localparam int PS_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [PS_W-1:0] ps_cnt;     // Clocks spent on the current digit
    logic [2:0]      digit;
    logic            started;    // Display stays dark until the first step
    logic            step;
    logic [3:0]      nibble;

    assign step = (ps_cnt == PS_W'(SCAN_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            ps_cnt  <= '0;
            digit   <= '0;
            started <= 1'b0;
        end else if (step) begin
            ps_cnt  <= '0;
            digit   <= digit + 3'd1;
            started <= 1'b1;
        end else begin
            ps_cnt <= ps_cnt + 1'b1;
        end
    end

    assign seg_an = started ? ~(8'b1 << digit) : 8'hff;
    assign nibble = value[4*digit +: 4];

    // Segment a is bit 0 and a low level lights a segment
    always_comb begin
        case (nibble)
            4'h0: seg_cathode = ~7'h3f;
            4'h1: seg_cathode = ~7'h06;
            4'h2: seg_cathode = ~7'h5b;
            4'h3: seg_cathode = ~7'h4f;
            4'h4: seg_cathode = ~7'h66;
            4'h5: seg_cathode = ~7'h6d;
            4'h6: seg_cathode = ~7'h7d;
            4'h7: seg_cathode = ~7'h07;
            4'h8: seg_cathode = ~7'h7f;
            4'h9: seg_cathode = ~7'h6f;
            4'ha: seg_cathode = ~7'h77;
            4'hb: seg_cathode = ~7'h7c;
            4'hc: seg_cathode = ~7'h39;
            4'hd: seg_cathode = ~7'h5e;
            4'he: seg_cathode = ~7'h79;
            default: seg_cathode = ~7'h71;
        endcase
    end

endmodule

/* io_top.sv */
`timescale 1ns/1ps

module io_top #(
    parameter int KB_FIFO_DEPTH = 8,
    parameter int RAM_BYTES     = soc_pkg::RAM_LEN,
    parameter int SCAN_CYCLES   = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] mem_raddr,
    input  logic [soc_pkg::ADDR_WIDTH-1:0] mem_waddr,
    input  logic [soc_pkg::REG_WIDTH-1:0]  mem_wdata,
    input  logic                           mem_wen,
    input  logic                           mem_ren,
    input  soc_pkg::wdt_e                  mem_wdt_op,
    input  logic                           ps2_clk,
    input  logic                           ps2_data,
    input  logic [soc_pkg::SWT_WIDTH-1:0]  swt,
    output logic [soc_pkg::REG_WIDTH-1:0]  mem_rdata,
    output logic [soc_pkg::LED_WIDTH-1:0]  led,
    output logic [7:0]                     seg_an,
    output logic [6:0]                     seg_cathode
);
    import soc_pkg::*;

    logic [KB_WIDTH-1:0]  code;
    logic                 code_valid;
    logic [KB_WIDTH-1:0]  kb_rdata;
    logic                 kb_ready;
    logic                 sig_rd_kb;
    logic [SEG_WIDTH-1:0] seg_value;

    mem_if ram_bus ();

    ps2_kbd_rx u_kbd_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid)
    );

    kb_fifo #(.KB_FIFO_DEPTH(KB_FIFO_DEPTH)) u_kb_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (code_valid),
        .push_data (code),
        .pop       (sig_rd_kb),
        .head      (kb_rdata),
        .not_empty (kb_ready)
    );

    mmio u_mmio (
        .clk        (clk),
        .rst        (rst),
        .mem_raddr  (mem_raddr),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wen    (mem_wen),
        .mem_ren    (mem_ren),
        .mem_wdt_op (mem_wdt_op),
        .kb_rdata   (kb_rdata),
        .kb_ready   (kb_ready),
        .swt_rdata  (swt),
        .mem_rdata  (mem_rdata),
        .sig_rd_kb  (sig_rd_kb),
        .seg_wdata  (seg_value),
        .led_wdata  (led),
        .ram        (ram_bus.ctrl)
    );

    data_ram #(.RAM_BYTES(RAM_BYTES)) u_data_ram (
        .clk (clk),
        .bus (ram_bus.mem)
    );

    seg_scan #(.SCAN_CYCLES(SCAN_CYCLES)) u_seg_scan (
        .clk         (clk),
        .rst         (rst),
        .value       (seg_value),
        .seg_an      (seg_an),
        .seg_cathode (seg_cathode)
    );

endmodule

/* tb_io_top.sv */
`timescale 1ns/1ps

module tb_io_top;
    import soc_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int HALF_PERIOD   = CLK_PERIOD / 2;
    localparam int KB_FIFO_DEPTH = 8;
    localparam int RAM_BYTES     = RAM_LEN;
    localparam int SCAN_CYCLES   = 4;
    localparam int RAM_AW        = $clog2(RAM_BYTES);
    localparam int PS2_HOLD      = 8;     // System clocks per ps2_clk level
    localparam int REGION_BYTES  = 256;   // RAM area used by the random loads and stores
    localparam int RAM_ROUNDS    = 48;

    // Frames and bus operations issued by the stimulus below
    localparam int NUM_FRAMES  = 5 + 2 + (KB_FIFO_DEPTH + 2);
    localparam int NUM_BUS_OPS = REGION_BYTES / 8 + RAM_ROUNDS * 8 + 19 + 6 + 4 + 1;
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD
                               * (NUM_FRAMES * 11 * 2 * PS2_HOLD + NUM_BUS_OPS * 2
                                  + 2 * 8 * SCAN_CYCLES);

    logic                  clk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] mem_raddr;
    logic [ADDR_WIDTH-1:0] mem_waddr;
    logic [REG_WIDTH-1:0]  mem_wdata;
    logic                  mem_wen;
    logic                  mem_ren;
    wdt_e                  mem_wdt_op;
    logic                  ps2_clk;
    logic                  ps2_data;
    logic [SWT_WIDTH-1:0]  swt;
    logic [REG_WIDTH-1:0]  mem_rdata;
    logic [LED_WIDTH-1:0]  led;
    logic [7:0]            seg_an;
    logic [6:0]            seg_cathode;

    // Reference model
    logic [7:0]           ram_model [RAM_BYTES];
    logic [7:0]           kb_model [$];
    logic [LED_WIDTH-1:0] led_model;
    logic [SEG_WIDTH-1:0] seg_model;
    logic [6:0]           hex_tab [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
                                           7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e,
                                           7'h79, 7'h71};   // Active high with segment a in bit 0

    integer seed;
    int     errors = 0;
    int     checks = 0;

    io_top #(
        .KB_FIFO_DEPTH (KB_FIFO_DEPTH),
        .RAM_BYTES     (RAM_BYTES),
        .SCAN_CYCLES   (SCAN_CYCLES)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .mem_raddr   (mem_raddr),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_wen     (mem_wen),
        .mem_ren     (mem_ren),
        .mem_wdt_op  (mem_wdt_op),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .swt         (swt),
        .mem_rdata   (mem_rdata),
        .led         (led),
        .seg_an      (seg_an),
        .seg_cathode (seg_cathode)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // Both checked on the falling edge, where neither side is changing
    assert property (@(negedge clk) disable iff (rst) led == led_model)
    else begin
        errors++;
        $display("MISMATCH at %0t ns: led %h expected %h", $time, led, led_model);
    end

    assert property (@(negedge clk) disable iff (rst) (seg_an == 8'hff) || $onehot(~seg_an))
    else begin
        errors++;
        $display("At %0t ns more than one digit anode is enabled: %b", $time, seg_an);
    end

    function automatic int access_bytes(input wdt_e op);
        case (op)
            WDT_B, WDT_BU: return 1;
            WDT_H, WDT_HU: return 2;
            WDT_W, WDT_WU: return 4;
            default:       return 8;
        endcase
    endfunction

    function automatic logic in_ram_window(input logic [ADDR_WIDTH-1:0] addr);
        return (addr >= ADDR_RAM) && (addr < ADDR_RAM + 64'(RAM_BYTES));
    endfunction

    function automatic logic [63:0] rand_dword();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Naturally aligned address inside the tested RAM region
    function automatic logic [63:0] ram_addr_for(input wdt_e op);
        int off;
        off = int'($unsigned($random(seed)) % REGION_BYTES);
        off = off & ~(access_bytes(op) - 1);
        return ADDR_RAM + 64'(off);
    endfunction

    function automatic logic [63:0] expected_load(input logic [63:0] addr, input wdt_e op);
        logic [63:0] raw;
        int          n;
        int          sh;
        logic [RAM_AW-1:0] base;
        n    = access_bytes(op);
        sh   = 64 - 8 * n;
        base = RAM_AW'(addr - ADDR_RAM);
        raw  = '0;
        for (int i = 0; i < n; i++) begin
            raw = raw | (64'(ram_model[base + RAM_AW'(i)]) << (8 * i));
        end
        if ((op == WDT_B || op == WDT_H || op == WDT_W) && n < 8) begin
            raw = 64'($signed(raw << sh) >>> sh);   // Replicate the field's top bit
        end
        return raw;
    endfunction

    function automatic int digit_of(input logic [7:0] an);
        int d;
        d = -1;
        for (int i = 0; i < 8; i++) begin
            if (an == ~(8'b1 << i)) d = i;
        end
        return d;
    endfunction

    task automatic write_bus(input logic [63:0] addr, input logic [63:0] data, input wdt_e op);
        logic [RAM_AW-1:0] base;
        @(negedge clk);
        mem_waddr  = addr;
        mem_wdata  = data;
        mem_wdt_op = op;
        mem_wen    = 1'b1;
        #(HALF_PERIOD - 1);
        if (in_ram_window(addr)) begin
            base = RAM_AW'(addr - ADDR_RAM);
            for (int i = 0; i < access_bytes(op); i++) begin
                ram_model[base + RAM_AW'(i)] = 8'(data >> (8 * i));
            end
        end
        if (addr[63:3] == LED_ADDR[63:3]) led_model = data[LED_WIDTH-1:0];
        if (addr[63:3] == SEG_ADDR[63:3]) seg_model = data[SEG_WIDTH-1:0];
        @(negedge clk);
        mem_wen = 1'b0;
    endtask

    task automatic read_bus(input logic [63:0] addr, input wdt_e op, input logic ren,
                            output logic [63:0] data);
        @(negedge clk);
        mem_raddr  = addr;
        mem_wdt_op = op;
        mem_ren    = ren;
        #(HALF_PERIOD - 1);
        data = mem_rdata;          // Just before the edge that may pop the FIFO
        @(negedge clk);
        mem_ren = 1'b0;
    endtask

    task automatic expect_read(input logic [63:0] addr, input wdt_e op, input logic ren,
                               input logic [63:0] exp, input string what);
        logic [63:0] got;
        read_bus(addr, op, ren, got);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("MISMATCH at %0t ns: %s at %h got %h expected %h",
                     $time, what, addr, got, exp);
        end
    endtask

    task automatic expect_kbd();
        logic [63:0] exp;
        exp = '0;
        if (kb_model.size() > 0) exp = 64'(kb_model.pop_front());
        expect_read(KBD_ADDR, WDT_D, 1'b1, exp, "keyboard read");
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        repeat (11) begin
            @(negedge clk);
            ps2_data = frame[0];
            frame    = frame >> 1;
            repeat (PS2_HOLD - 1) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HOLD) @(negedge clk);
            ps2_clk = 1'b1;
        end
        if (!bad_parity && kb_model.size() < KB_FIFO_DEPTH) kb_model.push_back(code);
    endtask

    task automatic check_segments();
        logic [7:0] seen;
        int         d;
        seen = '0;
        repeat (8 * SCAN_CYCLES) begin
            @(negedge clk);
            d = digit_of(seg_an);
            checks++;
            assert (d >= 0)
            else begin
                errors++;
                $display("At %0t ns no single digit is enabled: seg_an %b", $time, seg_an);
            end
            if (d >= 0) begin
                seen = seen | (8'b1 << d);
                assert (seg_cathode == ~hex_tab[4'(seg_model >> (4 * d))])
                else begin
                    errors++;
                    $display("MISMATCH at %0t ns: digit %0d cathodes %b for value %h",
                             $time, d, seg_cathode, seg_model);
                end
            end
        end
        assert (seen == 8'hff)
        else begin
            errors++;
            $display("Some digits were never scanned, seen mask %b", seen);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [63:0] data;
        logic [63:0] waddr;
        wdt_e        op;
        seed       = 32'h53258606;
        clk        = 1'b0;
        rst        = 1'b1;
        mem_raddr  = '0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        mem_wen    = 1'b0;
        mem_ren    = 1'b0;
        mem_wdt_op = WDT_D;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        swt        = '0;
        led_model  = '0;
        seg_model  = '0;

        repeat (16) @(negedge clk);
        assert (led == '0 && seg_an == 8'hff && mem_rdata == '0)
        else begin
            errors++;
            $display("Outputs are not in their reset state at %0t ns", $time);
        end
        rst = 1'b0;

        // Every region doubleword is defined first so no RAM load sees X
        for (int w = 0; w < REGION_BYTES / 8; w++) begin
            write_bus(ADDR_RAM + 64'(8 * w), rand_dword(), WDT_D);
        end
        for (int t = 0; t < RAM_ROUNDS; t++) begin
            op    = wdt_e'($unsigned($random(seed)) % 7);
            waddr = ram_addr_for(op);
            write_bus(waddr, rand_dword(), op);
            for (int k = 0; k < 7; k++) begin
                op   = wdt_e'(k);
                // A field of the doubleword just stored
                data = {waddr[63:3], 3'b000} | (ram_addr_for(op) & 64'h7);
                expect_read(data, op, 1'b1, expected_load(data, op), "RAM load");
            end
        end

        // Keyboard order with a read that has ren low in between
        repeat (5) send_ps2(8'($random(seed)), 1'b0);
        expect_kbd();
        expect_read(KBD_ADDR, WDT_D, 1'b0, '0, "keyboard read with ren low");
        repeat (5) expect_kbd();   // The fifth finds the FIFO empty

        // Keyboard faults
        send_ps2(8'h5a, 1'b1);
        expect_kbd();
        send_ps2(8'h1c, 1'b0);
        repeat (2) expect_kbd();
        repeat (KB_FIFO_DEPTH + 2) send_ps2(8'($random(seed)), 1'b0);
        repeat (KB_FIFO_DEPTH + 1) expect_kbd();

        // Switches and unmapped reads
        @(negedge clk);
        swt = 8'($random(seed));
        expect_read(SWT_ADDR, WDT_B, 1'b1, 64'(swt), "switch read");
        expect_read(64'h0, WDT_D, 1'b1, '0, "unmapped read");
        expect_read(ADDR_RAM + 64'(RAM_BYTES), WDT_D, 1'b1, '0, "read past RAM");
        expect_read(64'h0000_0000_A000_0100, WDT_D, 1'b1, '0, "unmapped read");

        // The concurrent check covers the LED in every other cycle
        write_bus(LED_ADDR, rand_dword(), WDT_D);
        checks++;
        assert (led == led_model)
        else begin
            errors++;
            $display("MISMATCH at %0t ns: led %h after write, expected %h", $time, led, led_model);
        end
        write_bus(ADDR_RAM + 64'(REGION_BYTES), rand_dword(), WDT_D);
        write_bus(64'h0000_0000_A000_00A0, rand_dword(), WDT_D);
        write_bus(LED_ADDR, rand_dword(), WDT_H);
        expect_read(LED_ADDR, WDT_D, 1'b1, '0, "LED register read");

        // Seven-segment scan
        write_bus(SEG_ADDR, rand_dword(), WDT_W);
        expect_read(SEG_ADDR, WDT_D, 1'b1, '0, "segment register read");
        check_segments();

        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
soc_pkg.sv
mem_if.sv
ps2_kbd_rx.sv
kb_fifo.sv
data_ram.sv
mmio.sv
seg_scan.sv
io_top.sv
tb_io_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_io_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
